/* common/gfx_pkg.sv */
package gfx_pkg;

  // pixel format, 4 bits per channel, red in the top nibble
  localparam int PIXEL_BITS     = 12;
  localparam int COLOR_BITS     = 4;
  localparam int PIXEL_AGE_BITS = 4;
  // stored word is {age, red, grn, blu}
  localparam int FB_WORD_BITS   = PIXEL_AGE_BITS + PIXEL_BITS;

  // horizontal timing in clocks
  localparam int H_VISIBLE     = 8;
  localparam int H_FRONT_PORCH = 1;
  localparam int H_SYNC_PULSE  = 2;
  localparam int H_BACK_PORCH  = 1;
  localparam int H_WHOLE_LINE  = H_VISIBLE + H_FRONT_PORCH + H_SYNC_PULSE + H_BACK_PORCH;
  localparam int H_SYNC_START  = H_VISIBLE + H_FRONT_PORCH;
  localparam int H_SYNC_END    = H_SYNC_START + H_SYNC_PULSE;
  localparam int H_CNT_BITS    = $clog2(H_WHOLE_LINE);

  // vertical timing in lines
  localparam int V_VISIBLE     = 4;
  localparam int V_FRONT_PORCH = 1;
  localparam int V_SYNC_PULSE  = 1;
  localparam int V_BACK_PORCH  = 0;
  localparam int V_WHOLE_FRAME = V_VISIBLE + V_FRONT_PORCH + V_SYNC_PULSE + V_BACK_PORCH;
  localparam int V_SYNC_START  = V_VISIBLE + V_FRONT_PORCH;
  localparam int V_SYNC_END    = V_SYNC_START + V_SYNC_PULSE;
  localparam int V_CNT_BITS    = $clog2(V_WHOLE_FRAME);

  // client coordinates and framebuffer addressing
  localparam int FB_X_BITS    = 3;
  localparam int FB_Y_BITS    = 2;
  localparam int FB_ADDR_BITS = 5;

  // fading
  localparam logic [PIXEL_AGE_BITS-1:0] FADE_AGE_NEW = 4'd4;
  localparam logic [PIXEL_AGE_BITS-1:0] FADE_AGE_DIM = 4'd2;
  localparam int FADE_QUEUE_DEPTH     = 8;
  localparam int FADE_QUEUE_PTR_BITS  = $clog2(FADE_QUEUE_DEPTH);

endpackage

/* fade/fade_stage.sv */
`timescale 1ns/10ps

module fade_stage (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             tap_valid,
  input  logic [gfx_pkg::FB_ADDR_BITS-1:0] tap_addr,
  input  logic [gfx_pkg::FB_WORD_BITS-1:0] tap_word,
  output logic                             fade_valid,
  input  logic                             fade_ready,
  output logic [gfx_pkg::FB_ADDR_BITS-1:0] fade_addr,
  output logic [gfx_pkg::FB_WORD_BITS-1:0] fade_word
);

  localparam int QUEUE_BITS = gfx_pkg::FB_ADDR_BITS + gfx_pkg::FB_WORD_BITS;

  logic [gfx_pkg::PIXEL_AGE_BITS-1:0] age;
  logic [gfx_pkg::PIXEL_AGE_BITS-1:0] next_age;
  logic [gfx_pkg::COLOR_BITS-1:0]     red;
  logic [gfx_pkg::COLOR_BITS-1:0]     grn;
  logic [gfx_pkg::COLOR_BITS-1:0]     blu;
  logic [gfx_pkg::PIXEL_BITS-1:0]     next_color;
  logic                               fade_hit;

  logic                             push_q;
  logic [gfx_pkg::FB_ADDR_BITS-1:0] push_addr_q;
  logic [gfx_pkg::FB_WORD_BITS-1:0] push_word_q;
  logic                             queue_full;
  logic                             queue_empty;

  assign {age, red, grn, blu} = tap_word;
  assign fade_hit = tap_valid && (age != '0);
  assign next_age = age - 1'b1;

  always_comb begin
    if (next_age == '0) begin
      next_color = '0;
    end else if (next_age == gfx_pkg::FADE_AGE_DIM) begin
      // dim step, every channel at half brightness
      next_color = {red >> 1, grn >> 1, blu >> 1};
    end else begin
      next_color = {red, grn, blu};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      push_q <= 1'b0;
    end else begin
      push_q <= fade_hit;
    end
  end

  always_ff @(posedge clk) begin
    push_addr_q <= tap_addr;
    push_word_q <= {next_age, next_color};
  end

  sync_fifo #(
    .DATA_WIDTH(QUEUE_BITS)
  ) fade_queue_i (
    .clk      (clk),
    .rst      (rst),
    .push     (push_q),
    .push_data({push_addr_q, push_word_q}),
    .full     (queue_full),
    .pop      (fade_ready),
    .pop_data ({fade_addr, fade_word}),
    .empty    (queue_empty)
  );

  assign fade_valid = !queue_empty;

  // a visible line yields at most 8 entries, the writer drains with priority
  a_no_overflow: assert property (
    @(posedge clk) disable iff (rst) push_q |-> !queue_full
  );

endmodule

/* fade/sync_fifo.sv */
`timescale 1ns/10ps

module sync_fifo #(
  parameter int DATA_WIDTH = 8
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  push,
  input  logic [DATA_WIDTH-1:0] push_data,
  output logic                  full,
  input  logic                  pop,
  output logic [DATA_WIDTH-1:0] pop_data,
  output logic                  empty
);

  localparam int PTR_BITS = gfx_pkg::FADE_QUEUE_PTR_BITS;

  logic [DATA_WIDTH-1:0] mem [0:gfx_pkg::FADE_QUEUE_DEPTH-1];
  logic [PTR_BITS-1:0]   wr_ptr;
  logic [PTR_BITS-1:0]   rd_ptr;
  logic [PTR_BITS:0]     count;
  logic                  do_push;
  logic                  do_pop;

  assign full     = count == (PTR_BITS + 1)'(gfx_pkg::FADE_QUEUE_DEPTH);
  assign empty    = count == '0;
  assign do_push  = push && !full;
  assign do_pop   = pop && !empty;
  assign pop_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_BITS'(gfx_pkg::FADE_QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_BITS'(gfx_pkg::FADE_QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  a_no_underflow: assert property (@(posedge clk) disable iff (rst) pop |-> !empty);

endmodule

/* hw/fb_ram.sv */
`timescale 1ns/10ps

module fb_ram (
  input  logic                             clk,
  input  logic                             wr_en,
  input  logic [gfx_pkg::FB_ADDR_BITS-1:0] wr_addr,
  input  logic [gfx_pkg::FB_WORD_BITS-1:0] wr_data,
  input  logic [gfx_pkg::FB_ADDR_BITS-1:0] rd_addr,
  output logic [gfx_pkg::FB_WORD_BITS-1:0] rd_data
);

  logic [gfx_pkg::FB_WORD_BITS-1:0] mem [0:(1 << gfx_pkg::FB_ADDR_BITS)-1];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // read-first so a same-cycle write shows up on the next read
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

/* hw/fb_writer_2to1.sv */
`timescale 1ns/10ps

module fb_writer_2to1 (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             gfx_valid,
  output logic                             gfx_ready,
  input  logic [   gfx_pkg::FB_X_BITS-1:0] gfx_x,
  input  logic [   gfx_pkg::FB_Y_BITS-1:0] gfx_y,
  input  logic [  gfx_pkg::PIXEL_BITS-1:0] gfx_color,
  input  logic                             fade_valid,
  output logic                             fade_ready,
  input  logic [gfx_pkg::FB_ADDR_BITS-1:0] fade_addr,
  input  logic [gfx_pkg::FB_WORD_BITS-1:0] fade_word,
  output logic                             wr_en,
  output logic [gfx_pkg::FB_ADDR_BITS-1:0] wr_addr,
  output logic [gfx_pkg::FB_WORD_BITS-1:0] wr_data
);

  logic [gfx_pkg::FB_ADDR_BITS-1:0] gfx_addr;
  logic [gfx_pkg::FB_WORD_BITS-1:0] gfx_word;

  assign gfx_addr = gfx_pkg::FB_ADDR_BITS'(int'(gfx_y) * gfx_pkg::H_VISIBLE + int'(gfx_x));
  // a fresh draw starts at full age
  assign gfx_word = {gfx_pkg::FADE_AGE_NEW, gfx_color};

  // write-backs always win and the client waits while any are pending
  assign fade_ready = fade_valid;
  assign gfx_ready  = !fade_valid;

  assign wr_en   = fade_valid || gfx_valid;
  assign wr_addr = fade_valid ? fade_addr : gfx_addr;
  assign wr_data = fade_valid ? fade_word : gfx_word;

  // client keeps its draw steady while it is stalled
  a_gfx_hold: assert property (
    @(posedge clk) disable iff (rst)
    (gfx_valid && !gfx_ready) |=> (gfx_valid && $stable({gfx_x, gfx_y, gfx_color}))
  );

endmodule

/* hw/gfx_vga_fade.sv */
`timescale 1ns/10ps

module gfx_vga_fade (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [  gfx_pkg::FB_X_BITS-1:0] gfx_x,
  input  logic [  gfx_pkg::FB_Y_BITS-1:0] gfx_y,
  input  logic [ gfx_pkg::PIXEL_BITS-1:0] gfx_color,
  input  logic                            gfx_valid,
  output logic                            gfx_ready,
  output logic                            gfx_vsync,
  input  logic                            vga_enable,
  output logic [ gfx_pkg::COLOR_BITS-1:0] vga_red,
  output logic [ gfx_pkg::COLOR_BITS-1:0] vga_grn,
  output logic [ gfx_pkg::COLOR_BITS-1:0] vga_blu,
  output logic                            vga_hsync,
  output logic                            vga_vsync
);

  // framebuffer ports
  logic                             wr_en;
  logic [gfx_pkg::FB_ADDR_BITS-1:0] wr_addr;
  logic [gfx_pkg::FB_WORD_BITS-1:0] wr_data;
  logic [gfx_pkg::FB_ADDR_BITS-1:0] rd_addr;
  logic [gfx_pkg::FB_WORD_BITS-1:0] rd_data;

  // scan engine tap into the fade stage
  logic                             tap_valid;
  logic [gfx_pkg::FB_ADDR_BITS-1:0] tap_addr;
  logic [gfx_pkg::FB_WORD_BITS-1:0] tap_word;

  // fade write-backs toward the writer
  logic                             fade_valid;
  logic                             fade_ready;
  logic [gfx_pkg::FB_ADDR_BITS-1:0] fade_addr;
  logic [gfx_pkg::FB_WORD_BITS-1:0] fade_word;

  fb_ram fb_ram_i (
    .clk    (clk),
    .wr_en  (wr_en),
    .wr_addr(wr_addr),
    .wr_data(wr_data),
    .rd_addr(rd_addr),
    .rd_data(rd_data)
  );

  vga_fb_pixel_stream vga_fb_pixel_stream_i (
    .clk       (clk),
    .rst       (rst),
    .vga_enable(vga_enable),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data),
    .tap_valid (tap_valid),
    .tap_addr  (tap_addr),
    .tap_word  (tap_word),
    .vga_hsync (vga_hsync),
    .vga_vsync (vga_vsync),
    .vga_red   (vga_red),
    .vga_grn   (vga_grn),
    .vga_blu   (vga_blu),
    .gfx_vsync (gfx_vsync)
  );

  fade_stage fade_stage_i (
    .clk       (clk),
    .rst       (rst),
    .tap_valid (tap_valid),
    .tap_addr  (tap_addr),
    .tap_word  (tap_word),
    .fade_valid(fade_valid),
    .fade_ready(fade_ready),
    .fade_addr (fade_addr),
    .fade_word (fade_word)
  );

  fb_writer_2to1 fb_writer_2to1_i (
    .clk       (clk),
    .rst       (rst),
    .gfx_valid (gfx_valid),
    .gfx_ready (gfx_ready),
    .gfx_x     (gfx_x),
    .gfx_y     (gfx_y),
    .gfx_color (gfx_color),
    .fade_valid(fade_valid),
    .fade_ready(fade_ready),
    .fade_addr (fade_addr),
    .fade_word (fade_word),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data)
  );

endmodule

/* pixel_stream/vga_fb_pixel_stream.sv */
`timescale 1ns/10ps

module vga_fb_pixel_stream (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             vga_enable,
  output logic [gfx_pkg::FB_ADDR_BITS-1:0] rd_addr,
  input  logic [gfx_pkg::FB_WORD_BITS-1:0] rd_data,
  output logic                             tap_valid,
  output logic [gfx_pkg::FB_ADDR_BITS-1:0] tap_addr,
  output logic [gfx_pkg::FB_WORD_BITS-1:0] tap_word,
  output logic                             vga_hsync,
  output logic                             vga_vsync,
  output logic [  gfx_pkg::COLOR_BITS-1:0] vga_red,
  output logic [  gfx_pkg::COLOR_BITS-1:0] vga_grn,
  output logic [  gfx_pkg::COLOR_BITS-1:0] vga_blu,
  output logic                             gfx_vsync
);

  logic [gfx_pkg::H_CNT_BITS-1:0] h_cnt;
  logic [gfx_pkg::V_CNT_BITS-1:0] v_cnt;
  logic                           h_last;
  logic                           v_last;
  logic                           visible;
  logic                           hsync;
  logic                           vsync;

  // flags delayed one cycle so they line up with rd_data
  logic                             s1_valid;
  logic                             s1_visible;
  logic                             s1_hsync;
  logic                             s1_vsync;
  logic [gfx_pkg::FB_ADDR_BITS-1:0] s1_addr;
  logic [  gfx_pkg::PIXEL_BITS-1:0] s1_color;

  assign h_last  = h_cnt == gfx_pkg::H_CNT_BITS'(gfx_pkg::H_WHOLE_LINE - 1);
  assign v_last  = v_cnt == gfx_pkg::V_CNT_BITS'(gfx_pkg::V_WHOLE_FRAME - 1);
  assign visible = (h_cnt < gfx_pkg::H_CNT_BITS'(gfx_pkg::H_VISIBLE)) &&
                   (v_cnt < gfx_pkg::V_CNT_BITS'(gfx_pkg::V_VISIBLE));
  assign hsync   = (h_cnt >= gfx_pkg::H_CNT_BITS'(gfx_pkg::H_SYNC_START)) &&
                   (h_cnt < gfx_pkg::H_CNT_BITS'(gfx_pkg::H_SYNC_END));
  assign vsync   = (v_cnt >= gfx_pkg::V_CNT_BITS'(gfx_pkg::V_SYNC_START)) &&
                   (v_cnt < gfx_pkg::V_CNT_BITS'(gfx_pkg::V_SYNC_END));

  // only meaningful for visible positions, blanking reads are ignored
  assign rd_addr = gfx_pkg::FB_ADDR_BITS'(int'(v_cnt) * gfx_pkg::H_VISIBLE + int'(h_cnt));

  always_ff @(posedge clk) begin
    if (rst) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (vga_enable) begin
      if (h_last) begin
        h_cnt <= '0;
        v_cnt <= v_last ? '0 : v_cnt + 1'b1;
      end else begin
        h_cnt <= h_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid   <= 1'b0;
      s1_visible <= 1'b0;
      s1_hsync   <= 1'b0;
      s1_vsync   <= 1'b0;
    end else begin
      s1_valid <= vga_enable;
      if (vga_enable) begin
        s1_visible <= visible;
        s1_hsync   <= hsync;
        s1_vsync   <= vsync;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (vga_enable) begin
      s1_addr <= rd_addr;
    end
  end

  // the fade stage sees each visible pixel once per frame
  assign tap_valid = s1_valid && s1_visible;
  assign tap_addr  = s1_addr;
  assign tap_word  = rd_data;
  assign s1_color  = rd_data[gfx_pkg::PIXEL_BITS-1:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      vga_hsync <= 1'b0;
      vga_vsync <= 1'b0;
      vga_red   <= '0;
      vga_grn   <= '0;
      vga_blu   <= '0;
    end else if (s1_valid) begin
      vga_hsync <= s1_hsync;
      vga_vsync <= s1_vsync;
      if (s1_visible) begin
        {vga_red, vga_grn, vga_blu} <= s1_color;
      end else begin
        {vga_red, vga_grn, vga_blu} <= '0;
      end
    end
  end

  assign gfx_vsync = vga_vsync;

  a_h_in_line: assert property (
    @(posedge clk) disable iff (rst) h_cnt < gfx_pkg::H_CNT_BITS'(gfx_pkg::H_WHOLE_LINE)
  );

endmodule

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f \
  --top-module gfx_vga_fade_tb -o gfx_vga_fade_sim

./obj_dir/gfx_vga_fade_sim > sim.log
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
  exit 1
fi
exit 0

/* sim.f */
common/gfx_pkg.sv
hw/fb_ram.sv
pixel_stream/vga_fb_pixel_stream.sv
fade/sync_fifo.sv
fade/fade_stage.sv
hw/fb_writer_2to1.sv
hw/gfx_vga_fade.sv
verif/gfx_vga_fade_tb.sv

/* verif/gfx_vga_fade_tb.sv */
`timescale 1ns/10ps

module gfx_vga_fade_tb;

  logic        clk;
  logic        rst;
  logic [2:0]  gfx_x;
  logic [1:0]  gfx_y;
  logic [11:0] gfx_color;
  logic        gfx_valid;
  logic        gfx_ready;
  logic        gfx_vsync;
  logic        vga_enable;
  logic [3:0]  vga_red;
  logic [3:0]  vga_grn;
  logic [3:0]  vga_blu;
  logic        vga_hsync;
  logic        vga_vsync;

  // draw table in the left half of the screen
  logic [2:0]  tab_x [8] = '{3'd0, 3'd1, 3'd2, 3'd3, 3'd0, 3'd1, 3'd2, 3'd3};
  logic [1:0]  tab_y [8] = '{2'd0, 2'd0, 2'd1, 2'd1, 2'd2, 2'd3, 2'd3, 2'd2};
  logic [11:0] tab_c [8] = '{12'hf00, 12'h0f0, 12'h00f, 12'hfff,
                             12'h8a4, 12'hc3e, 12'h777, 12'h1e9};

  // reference framebuffer
  logic [3:0]  m_age [32];
  logic [11:0] m_col [32];
  logic [11:0] frame_col [32];

  int   errors = 0;
  int   checks = 0;
  int   bp_hits = 0;
  logic bp_on = 1'b0;
  logic lit_prev = 1'b0;
  int   e0;

  gfx_vga_fade gfx_vga_fade_i (
    .clk       (clk),
    .rst       (rst),
    .gfx_x     (gfx_x),
    .gfx_y     (gfx_y),
    .gfx_color (gfx_color),
    .gfx_valid (gfx_valid),
    .gfx_ready (gfx_ready),
    .gfx_vsync (gfx_vsync),
    .vga_enable(vga_enable),
    .vga_red   (vga_red),
    .vga_grn   (vga_grn),
    .vga_blu   (vga_blu),
    .vga_hsync (vga_hsync),
    .vga_vsync (vga_vsync)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check_val(input string name, input int exp, input int got);
    checks++;
    assert (exp == got) else begin
      $display("[ERROR] %0t ns %s expected %0h got %0h", $time, name, exp, got);
      errors++;
    end
  endtask

  // outputs are stable 1 ns after the edge
  task automatic next_sample();
    @(posedge clk);
    #1;
  endtask

  task automatic check_reset_outputs();
    check_val("vga_hsync", 0, int'(vga_hsync));
    check_val("vga_vsync", 0, int'(vga_vsync));
    check_val("gfx_vsync", 0, int'(gfx_vsync));
    check_val("vga_rgb", 0, int'({vga_red, vga_grn, vga_blu}));
    check_val("gfx_ready", 1, int'(gfx_ready));
  endtask

  task automatic wait_vsync_rise();
    logic prev;
    logic found;
    int   n;
    prev  = vga_vsync;
    found = 1'b0;
    n     = 0;
    while (!found && n < 200) begin
      next_sample();
      n++;
      found = vga_vsync && !prev;
      prev  = vga_vsync;
    end
    if (!found) begin
      $display("timeout: vga_vsync did not rise within 200 cycles at %0t ns", $time);
      errors++;
    end
  endtask

  // called and returns at the drive point
  task automatic draw(input logic [2:0] x, input logic [1:0] y, input logic [11:0] c,
                      input int max_gap);
    int gap;
    int n;
    gap = int'($urandom % 32'(max_gap + 1));
    repeat (gap) begin
      @(posedge clk);
      #2;
    end
    gfx_x     = x;
    gfx_y     = y;
    gfx_color = c;
    gfx_valid = 1'b1;
    n = 0;
    while (!gfx_ready && n < 100) begin
      @(posedge clk);
      #2;
      n++;
    end
    if (!gfx_ready) begin
      $display("timeout: draw at x=%0d y=%0d was not accepted in 100 cycles", x, y);
      errors++;
    end
    @(posedge clk);
    #2;
    gfx_valid = 1'b0;
    m_age[int'(y) * 8 + int'(x)] = 4'd4;
    m_col[int'(y) * 8 + int'(x)] = c;
  endtask

  task automatic load_picture();
    for (int a = 0; a < 32; a++) begin
      draw(3'(a % 8), 2'(a / 8), 12'h000, 0);
    end
    for (int r = 0; r < 8; r++) begin
      draw(tab_x[r], tab_y[r], tab_c[r], 0);
    end
  endtask

  // one scan of every visible pixel
  task automatic fade_model();
    logic [11:0] c;
    for (int i = 0; i < 32; i++) begin
      if (m_age[i] != 4'd0) begin
        m_age[i] = m_age[i] - 4'd1;
        c = m_col[i];
        if (m_age[i] == 4'd0) begin
          m_col[i] = 12'h000;
        end else if (m_age[i] == 4'd2) begin
          m_col[i] = {c[11:8] >> 1, c[7:4] >> 1, c[3:0] >> 1};
        end
      end
    end
  endtask

  task automatic check_frozen(input logic [11:0] col, input logic hs, input logic vs);
    check_val("vga_rgb (stalled)", int'(col), int'({vga_red, vga_grn, vga_blu}));
    check_val("vga_hsync (stalled)", int'(hs), int'(vga_hsync));
    check_val("vga_vsync (stalled)", int'(vs), int'(vga_vsync));
  endtask

  // k = 0 is the sample where vga_vsync has just risen at position (0, 5)
  task automatic capture_frame(input int stall_k);
    int          h;
    int          v;
    logic        hs_exp;
    logic        vs_exp;
    logic [11:0] col;
    for (int k = 0; k < 72; k++) begin
      if (k > 0) next_sample();
      h      = k % 12;
      v      = (5 + k / 12) % 6;
      hs_exp = (h >= 9 && h < 11);
      vs_exp = (v == 5);
      col    = {vga_red, vga_grn, vga_blu};
      check_val("vga_hsync", int'(hs_exp), int'(vga_hsync));
      check_val("vga_vsync", int'(vs_exp), int'(vga_vsync));
      check_val("gfx_vsync", int'(vga_vsync), int'(gfx_vsync));
      if (h < 8 && v < 4) frame_col[v * 8 + h] = col;
      else check_val("vga_rgb (blank)", 0, int'(col));
      if (k == stall_k) begin
        #1;
        vga_enable = 1'b0;
      end
      // the pipeline drains one position and then everything holds
      if (stall_k >= 0 && k == stall_k + 1) begin
        repeat (19) begin
          next_sample();
          check_frozen(col, hs_exp, vs_exp);
        end
        #1;
        vga_enable = 1'b1;
        next_sample();
        check_frozen(col, hs_exp, vs_exp);
      end
    end
  endtask

  task automatic compare_model();
    for (int i = 0; i < 32; i++) begin
      check_val($sformatf("vga_rgb pixel %0d", i), int'(m_col[i]), int'(frame_col[i]));
    end
    fade_model();
  endtask

  task automatic measure_syncs();
    int   hs_rise;
    int   vs_rise;
    int   hs_len;
    int   vs_len;
    int   hs_seen;
    int   vs_seen;
    logic hs_prev;
    logic vs_prev;
    hs_rise = -1;
    vs_rise = -1;
    hs_len  = 0;
    vs_len  = 0;
    hs_seen = 0;
    vs_seen = 0;
    hs_prev = vga_hsync;
    vs_prev = vga_vsync;
    for (int n = 0; n < 160; n++) begin
      next_sample();
      check_val("gfx_vsync", int'(vga_vsync), int'(gfx_vsync));
      if (vga_hsync && !hs_prev) begin
        if (hs_rise >= 0) check_val("vga_hsync period", 12, n - hs_rise);
        hs_rise = n;
        hs_seen++;
      end
      if (vga_vsync && !vs_prev) begin
        if (vs_rise >= 0) check_val("vga_vsync period", 72, n - vs_rise);
        vs_rise = n;
        vs_seen++;
      end
      if (vga_hsync) hs_len++;
      else if (hs_prev) begin
        if (hs_rise >= 0) check_val("vga_hsync width", 2, hs_len);
        hs_len = 0;
      end
      if (vga_vsync) vs_len++;
      else if (vs_prev) begin
        if (vs_rise >= 0) check_val("vga_vsync width", 12, vs_len);
        vs_len = 0;
      end
      hs_prev = vga_hsync;
      vs_prev = vga_vsync;
    end
    if (hs_seen < 2 || vs_seen < 2) begin
      $display("sync pulses missing: %0d hsync and %0d vsync rises seen", hs_seen, vs_seen);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    $display("test %s: %s", name, (errors == errs_before) ? "ok" : "failed");
  endtask

  // a lit pixel means a fading tap and the writer must stall the client 2 cycles later
  initial begin
    forever begin
      next_sample();
      if (bp_on && lit_prev) begin
        bp_hits++;
        check_val("gfx_ready", 0, int'(gfx_ready));
      end
      lit_prev = ({vga_red, vga_grn, vga_blu} != 12'h000);
    end
  end

  initial begin
    void'($urandom(32'h3574));
    rst        = 1'b1;
    vga_enable = 1'b0;
    gfx_valid  = 1'b0;
    gfx_x      = '0;
    gfx_y      = '0;
    gfx_color  = '0;

    e0 = errors;
    repeat (5) begin
      next_sample();
      check_reset_outputs();
    end
    #1;
    rst = 1'b0;
    next_sample();
    check_reset_outputs();
    report_test("reset state", e0);

    // counters sit at (0, 0) and one full visible scan comes before the first vsync
    e0 = errors;
    #1;
    load_picture();
    vga_enable = 1'b1;
    fade_model();
    wait_vsync_rise();
    capture_frame(-1);
    compare_model();
    report_test("drawing", e0);

    e0 = errors;
    repeat (4) begin
      wait_vsync_rise();
      capture_frame(-1);
      compare_model();
    end
    report_test("fading", e0);

    e0 = errors;
    measure_syncs();
    report_test("sync geometry", e0);

    // every pixel has age 0 now and drawing while scanning is safe
    e0 = errors;
    wait_vsync_rise();
    #1;
    bp_on = 1'b1;
    for (int r = 0; r < 8; r++) draw(tab_x[r], tab_y[r], tab_c[r], 0);
    for (int r = 0; r < 8; r++) draw(tab_x[r] + 3'd4, tab_y[r], tab_c[r] ^ 12'h5a5, 2);
    wait_vsync_rise();
    capture_frame(-1);
    bp_on = 1'b0;
    for (int r = 0; r < 8; r++) begin
      check_val("vga_rgb old pixel", int'(tab_c[r]),
                int'(frame_col[int'(tab_y[r]) * 8 + int'(tab_x[r])]));
      check_val("vga_rgb new pixel", int'(tab_c[r] ^ 12'h5a5),
                int'(frame_col[int'(tab_y[r]) * 8 + int'(tab_x[r]) + 4]));
    end
    if (bp_hits == 0) begin
      $display("no fading tap was seen while the client was drawing");
      errors++;
    end
    report_test("back-pressure", e0);

    // freeze at (2, 5) so the model is back in step after the reload
    e0 = errors;
    wait_vsync_rise();
    #1;
    vga_enable = 1'b0;
    repeat (4) begin
      @(posedge clk);
      #2;
    end
    load_picture();
    vga_enable = 1'b1;
    fade_model();
    wait_vsync_rise();
    capture_frame(27);
    compare_model();
    wait_vsync_rise();
    capture_frame(-1);
    compare_model();
    report_test("stall", e0);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
